/* vlog.f */
design/mp_pkg.sv
design/mp_frame_if.sv
design/mp_setpoint_slew.sv
design/mp_error_stage.sv
design/mp_pi_clip.sv
design/mp_lock_detect.sv
design/mp_out_mux.sv
design/mp_proc_top.sv
tb/tb_mp_proc.sv

/* run_sim.sh */
#!/bin/sh
# build tb_mp_proc with verilator, run it, pass only if the log holds the pass line
rm -f build.log sim.log &&
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_mp_proc \
		-o tb_mp_proc > build.log 2>&1 &&
	{ ./obj_dir/tb_mp_proc > sim.log 2>&1 || true; } &&
	cat sim.log &&
	grep -qx "NO ERRORS" sim.log &&
	echo "simulation passed" ||
	{ cat build.log; echo "simulation failed"; exit 1; }

/* tb/tb_mp_proc.sv */
`timescale 1ns/10ps

module tb_mp_proc;

	localparam int n_fixed = 26;
	localparam int n_rand = 16;
	localparam int n_frames = n_fixed + n_rand;
	localparam int dw = mp_pkg::data_w;
	localparam int d_max = 2**(dw-1) - 1;
	localparam int d_min = -(2**(dw-1));

	logic clk;
	logic rst_n;
	logic sync;
	logic signed [dw-1:0] in_mp;
	logic signed [dw-1:0] set_m;
	logic signed [dw-1:0] set_p;
	logic [mp_pkg::gain_w-1:0] gain_kp;
	logic [mp_pkg::gain_w-1:0] gain_ki;
	logic signed [dw-1:0] lim_hi;
	logic signed [dw-1:0] lim_lo;
	logic sel_en;
	logic signed [dw-1:0] sel_thresh;
	logic signed [dw-1:0] ph_offset;
	logic slew_en;
	logic out_sync;
	logic signed [dw-1:0] out_xy;
	logic signed [dw-1:0] out_ph;
	logic [7:0] cmp_event;

	// frame table, one row per input frame
	logic signed [dw-1:0] r_mag [n_frames];
	logic signed [dw-1:0] r_pha [n_frames];
	logic signed [dw-1:0] r_setm [n_frames];
	logic signed [dw-1:0] r_setp [n_frames];
	logic [mp_pkg::gain_w-1:0] r_kp [n_frames];
	logic [mp_pkg::gain_w-1:0] r_ki [n_frames];
	logic signed [dw-1:0] r_lhi [n_frames];
	logic signed [dw-1:0] r_llo [n_frames];
	logic r_sel [n_frames];
	logic signed [dw-1:0] r_thr [n_frames];
	logic signed [dw-1:0] r_off [n_frames];
	logic r_slew [n_frames];
	int n_rows;
	int seed;

	// reference model state, carried from frame to frame
	logic signed [dw-1:0] slew_s;
	logic signed [mp_pkg::acc_w-1:0] integ_x;
	logic signed [mp_pkg::acc_w-1:0] integ_y;
	logic amp_q;
	// expected output frame of the last modeled measurement
	logic signed [dw-1:0] ex_xy [mp_pkg::frame_len];
	logic signed [dw-1:0] ex_ph [mp_pkg::frame_len];
	logic [7:0] ex_ev;

	mp_proc_top mp_proc_top_inst (
		.clk(clk), .rst_n(rst_n), .sync(sync), .in_mp(in_mp),
		.set_m(set_m), .set_p(set_p), .gain_kp(gain_kp), .gain_ki(gain_ki),
		.lim_hi(lim_hi), .lim_lo(lim_lo), .sel_en(sel_en), .sel_thresh(sel_thresh),
		.ph_offset(ph_offset), .slew_en(slew_en), .out_sync(out_sync),
		.out_xy(out_xy), .out_ph(out_ph), .cmp_event(cmp_event)
	);

	always #10 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "simulation stopped at the first mismatch");
		end
	endtask

	// columns: mag, pha, set_m, set_p, kp, ki, lim_hi, lim_lo, sel_en, thresh, offset, slew
	task automatic add_row(input int mag, input int pha, input int sm, input int sp,
			input int kp, input int ki, input int hi, input int lo, input int sel,
			input int thr, input int off, input int slew);
		r_mag[n_rows] = dw'(mag);
		r_pha[n_rows] = dw'(pha);
		r_setm[n_rows] = dw'(sm);
		r_setp[n_rows] = dw'(sp);
		r_kp[n_rows] = mp_pkg::gain_w'(kp);
		r_ki[n_rows] = mp_pkg::gain_w'(ki);
		r_lhi[n_rows] = dw'(hi);
		r_llo[n_rows] = dw'(lo);
		r_sel[n_rows] = sel[0];
		r_thr[n_rows] = dw'(thr);
		r_off[n_rows] = dw'(off);
		r_slew[n_rows] = slew[0];
		n_rows++;
	endtask

	task automatic build_table();
		// zero gains, setpoint scaling and set_p pass-through
		add_row(20000, 1000, 20000, 1000, 0, 0, 30000, -30000, 0, 10000, 0, 0);
		add_row(30000, -2000, 30000, 7000, 0, 0, 30000, -30000, 0, 10000, 0, 0);
		// slewed step up by 300, then back down
		for (int i = 0; i < 6; i++)
			add_row(30300, 0, 30300, 0, 0, 0, 30000, -30000, 0, 10000, 0, 1);
		for (int i = 0; i < 2; i++)
			add_row(30000, 0, 30000, 0, 0, 0, 30000, -30000, 0, 10000, 0, 1);
		// hysteresis 5000..10000, phase error integrates on y
		add_row(12000, 3000, 12000, 1000, 0, 256, 100000, -100000, 1, 10000, 500, 0);
		add_row(7000, 3000, 7000, 1000, 0, 256, 100000, -100000, 1, 10000, 500, 0);
		add_row(5000, 3000, 5000, 1000, 0, 256, 100000, -100000, 1, 10000, 500, 0);
		add_row(4999, 3000, 4999, 1000, 0, 256, 100000, -100000, 1, 10000, 500, 0);
		add_row(8000, 3000, 8000, 1000, 0, 256, 100000, -100000, 1, 10000, 500, 0);
		// constant error of +1000 on x and -1000 on y runs into the limits
		for (int i = 0; i < 7; i++)
			add_row(13000, 0, 12000, 1000, 16, 256, 5000, -5000, 1, 0, 0, 0);
		// lock thresholds 40/20 on x and 81/40 on y, just above and at them
		add_row(20521, 82, 20480, 0, 0, 0, 30000, -30000, 0, 10000, 0, 0);
		add_row(20520, 81, 20480, 0, 0, 0, 30000, -30000, 0, 10000, 0, 0);
		add_row(20459, -41, 20480, 0, 0, 0, 30000, -30000, 0, 10000, 0, 0);
		add_row(20460, -40, 20480, 0, 0, 0, 30000, -30000, 0, 10000, 0, 0);
		for (int i = 0; i < n_rand; i++) begin
			r_mag[n_rows] = dw'($random(seed) & 'h1ffff);
			r_pha[n_rows] = dw'($random(seed));
			r_setm[n_rows] = dw'($random(seed) & 'h1ffff);
			r_setp[n_rows] = dw'($random(seed));
			r_kp[n_rows] = mp_pkg::gain_w'($random(seed));
			r_ki[n_rows] = mp_pkg::gain_w'($random(seed));
			r_lhi[n_rows] = dw'($random(seed) & 'h1ffff);
			r_llo[n_rows] = dw'(-($random(seed) & 'h1ffff));
			r_sel[n_rows] = $random(seed) & 1;
			r_thr[n_rows] = dw'($random(seed) & 'h1ffff);
			r_off[n_rows] = dw'($random(seed));
			r_slew[n_rows] = $random(seed) & 1;
			n_rows++;
		end
	endtask

	// one PI axis, the integrator only takes the new sum if the drive stays in range
	task automatic pi_axis(input int f, input logic signed [dw-1:0] e,
			inout logic signed [mp_pkg::acc_w-1:0] acc,
			output logic signed [dw-1:0] d, output logic hi, output logic lo);
		longint i_t;
		longint p_t;
		longint raw;
		logic signed [mp_pkg::acc_w-1:0] nx;
		i_t = (longint'(e) * longint'(r_ki[f])) >>> mp_pkg::ki_shift;
		p_t = (longint'(e) * longint'(r_kp[f])) >>> mp_pkg::kp_shift;
		nx = acc + mp_pkg::acc_w'(i_t);
		raw = longint'(nx) + p_t;
		hi = raw > longint'(r_lhi[f]);
		lo = raw < longint'(r_llo[f]);
		if (hi)
			d = r_lhi[f];
		else if (lo)
			d = r_llo[f];
		else
			d = dw'(raw);
		if (!(hi || lo))
			acc = nx;
	endtask

	task automatic model_frame(input int f);
		int diff;
		int m_err;
		int ax;
		int ay;
		int thr;
		logic signed [dw-1:0] ex;
		logic signed [dw-1:0] ey;
		logic signed [dw-1:0] dx;
		logic signed [dw-1:0] dy;
		// x-high, y-high, x-low, y-low from bit 0 up
		logic [3:0] clip;
		if (!r_slew[f]) begin
			slew_s = r_setm[f];
		end else begin
			diff = int'(r_setm[f]) - int'(slew_s);
			if (diff > mp_pkg::slew_step)
				slew_s = dw'(int'(slew_s) + mp_pkg::slew_step);
			else if (diff < -mp_pkg::slew_step)
				slew_s = dw'(int'(slew_s) - mp_pkg::slew_step);
			else
				slew_s = r_setm[f];
		end
		m_err = int'(r_mag[f]) - int'(slew_s);
		if (m_err > d_max)
			ex = dw'(d_max);
		else if (m_err < d_min)
			ex = dw'(d_min);
		else
			ex = dw'(m_err);
		// phase error wraps around the circle
		ey = r_pha[f] - r_setp[f];
		if (r_mag[f] > r_thr[f])
			amp_q = 1'b1;
		else if (r_mag[f] < (r_thr[f] >>> 1))
			amp_q = 1'b0;
		pi_axis(f, ex, integ_x, dx, clip[0], clip[2]);
		pi_axis(f, ey, integ_y, dy, clip[1], clip[3]);
		if (!amp_q)
			integ_y = '0;
		thr = int'(slew_s) >>> mp_pkg::thresh_shift;
		ax = (ex < 0) ? -int'(ex) : int'(ex);
		ay = (ey < 0) ? -int'(ey) : int'(ey);
		ex_ev = {clip,
			ay > (mp_pkg::ph_one_rad >> (mp_pkg::thresh_shift + 1)),
			ay > (mp_pkg::ph_one_rad >> mp_pkg::thresh_shift),
			ax > (thr >>> 1),
			ax > thr};
		for (int k = 0; k < mp_pkg::frame_len; k++) begin
			ex_xy[k] = '0;
			ex_ph[k] = '0;
		end
		ex_xy[0] = dx;
		ex_xy[1] = dy;
		ex_xy[2] = dw'((longint'(slew_s) * mp_pkg::set_scale) >>> mp_pkg::set_shift);
		ex_ph[1] = (r_sel[f] && amp_q) ? r_pha[f] + r_off[f] : '0;
		ex_ph[3] = r_setp[f];
	endtask

	// frame parameters change with sync and hold for the whole frame
	task automatic drive_cycle(input int f, input int k);
		sync = (k == 0);
		if (k == 0) begin
			in_mp = r_mag[f];
			set_m = r_setm[f];
			set_p = r_setp[f];
			gain_kp = r_kp[f];
			gain_ki = r_ki[f];
			lim_hi = r_lhi[f];
			lim_lo = r_llo[f];
			sel_en = r_sel[f];
			sel_thresh = r_thr[f];
			ph_offset = r_off[f];
			slew_en = r_slew[f];
		end else if (k == 1) begin
			in_mp = r_pha[f];
		end else begin
			// junk outside the two input slots must be ignored
			in_mp = dw'($random(seed));
		end
	endtask

	// outputs of frame f-1 play out while frame f is driven
	task automatic check_slot(input int f, input int k);
		check($sformatf("frame %0d out_sync slot %0d", f - 1, k), out_sync, (k == 0) && (f > 0));
		check($sformatf("frame %0d out_xy slot %0d", f - 1, k), out_xy, ex_xy[k]);
		check($sformatf("frame %0d out_ph slot %0d", f - 1, k), out_ph, ex_ph[k]);
		if (k == 0)
			check($sformatf("frame %0d cmp_event", f - 1), cmp_event, ex_ev);
	endtask

	// watchdog, reset plus every frame and the trailing one, with margin
	initial begin
		#((n_frames + 2) * mp_pkg::frame_len * 20 + 1000);
		$display("timeout, the frame loop did not finish in time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 51735;
		n_rows = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		sync = 1'b0;
		in_mp = '0;
		set_m = '0;
		set_p = '0;
		gain_kp = '0;
		gain_ki = '0;
		lim_hi = '0;
		lim_lo = '0;
		sel_en = 1'b0;
		sel_thresh = '0;
		ph_offset = '0;
		slew_en = 1'b0;
		slew_s = '0;
		integ_x = '0;
		integ_y = '0;
		amp_q = 1'b0;
		ex_ev = '0;
		for (int k = 0; k < mp_pkg::frame_len; k++) begin
			ex_xy[k] = '0;
			ex_ph[k] = '0;
		end
		build_table();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// one extra frame at the end flushes the last measurement out
		for (int f = 0; f <= n_frames; f++) begin
			for (int k = 0; k < mp_pkg::frame_len; k++) begin
				@(posedge clk);
				#1;
				check_slot(f, k);
				drive_cycle((f < n_frames) ? f : n_frames - 1, k);
			end
			if (f < n_frames)
				model_frame(f);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* design/mp_proc_top.sv */
`timescale 1ns/10ps

module mp_proc_top (
	input logic clk,
	input logic rst_n,
	input logic sync,
	// magnitude in slot 0, phase in slot 1
	input logic signed [mp_pkg::data_w-1:0] in_mp,
	input logic signed [mp_pkg::data_w-1:0] set_m,
	input logic signed [mp_pkg::data_w-1:0] set_p,
	input logic [mp_pkg::gain_w-1:0] gain_kp,
	input logic [mp_pkg::gain_w-1:0] gain_ki,
	input logic signed [mp_pkg::data_w-1:0] lim_hi,
	input logic signed [mp_pkg::data_w-1:0] lim_lo,
	input logic sel_en,
	input logic signed [mp_pkg::data_w-1:0] sel_thresh,
	input logic signed [mp_pkg::data_w-1:0] ph_offset,
	input logic slew_en,
	output logic out_sync,
	output logic signed [mp_pkg::data_w-1:0] out_xy,
	output logic signed [mp_pkg::data_w-1:0] out_ph,
	output logic [7:0] cmp_event
);

	logic signed [mp_pkg::data_w-1:0] drv_p;
	logic amp_ok;
	logic [3:0] clipped;

	// stage links
	mp_frame_if meas_if ();
	mp_frame_if setp_if ();
	mp_frame_if err_if ();
	mp_frame_if drv_if ();

	mp_setpoint_slew mp_setpoint_slew_inst (
		.clk(clk), .rst_n(rst_n), .sync(sync), .in_mp(in_mp),
		.set_m(set_m), .set_p(set_p), .slew_en(slew_en),
		.meas(meas_if.src), .setp(setp_if.src)
	);

	mp_error_stage mp_error_stage_inst (
		.clk(clk), .rst_n(rst_n), .meas(meas_if.dst), .setp(setp_if.dst),
		.sel_en(sel_en), .sel_thresh(sel_thresh), .ph_offset(ph_offset),
		.err(err_if.src), .drv_p(drv_p), .amp_ok(amp_ok)
	);

	mp_pi_clip mp_pi_clip_inst (
		.clk(clk), .rst_n(rst_n), .err(err_if.dst), .amp_ok(amp_ok),
		.gain_kp(gain_kp), .gain_ki(gain_ki), .lim_hi(lim_hi), .lim_lo(lim_lo),
		.drv(drv_if.src), .clipped(clipped)
	);

	// lock thresholds follow the slewed setpoint
	mp_lock_detect mp_lock_detect_inst (
		.clk(clk), .rst_n(rst_n), .err(err_if.dst), .set_mag(setp_if.x),
		.clipped(clipped), .cmp_event(cmp_event)
	);

	mp_out_mux mp_out_mux_inst (
		.clk(clk), .rst_n(rst_n), .sync(sync), .drv(drv_if.dst),
		.set_mag(setp_if.x), .set_p(setp_if.y), .drv_p(drv_p),
		.out_sync(out_sync), .out_xy(out_xy), .out_ph(out_ph)
	);

endmodule

/* design/mp_out_mux.sv */
`timescale 1ns/10ps

module mp_out_mux (
	input logic clk,
	input logic rst_n,
	input logic sync,
	mp_frame_if.dst drv,
	input logic signed [mp_pkg::data_w-1:0] set_mag,
	input logic signed [mp_pkg::data_w-1:0] set_p,
	input logic signed [mp_pkg::data_w-1:0] drv_p,
	output logic out_sync,
	output logic signed [mp_pkg::data_w-1:0] out_xy,
	output logic signed [mp_pkg::data_w-1:0] out_ph
);

	// sync delay line, one frame long
	logic [mp_pkg::frame_len-1:0] sync_sr;
	// slot now on the outputs, and the one coming next
	mp_pkg::mp_slot_e oslot;
	mp_pkg::mp_slot_e nxt;
	logic signed [2*mp_pkg::data_w-1:0] set_prod;
	logic take;
	logic signed [mp_pkg::data_w-1:0] lat_x;
	logic signed [mp_pkg::data_w-1:0] lat_y;
	logic signed [mp_pkg::data_w-1:0] lat_p;
	logic signed [mp_pkg::data_w-1:0] lat_sp;
	logic signed [mp_pkg::data_w-1:0] lat_set;
	logic signed [mp_pkg::data_w-1:0] xy_nx;
	logic signed [mp_pkg::data_w-1:0] ph_nx;

	assign out_sync = sync_sr[mp_pkg::frame_len-1];

	// x setpoint with cordic gain correction
	assign set_prod = set_mag * mp_pkg::set_scale;

	// drive pair always lands in slot 4 of the input frame
	assign take = drv.stb && (drv.slot == mp_pkg::slot_4);

	// outputs are registered, so look one slot ahead of out_sync
	assign nxt = sync_sr[mp_pkg::frame_len-2] ? mp_pkg::slot_mag
		: mp_pkg::mp_slot_e'(oslot + 3'd1);

	always_comb begin
		xy_nx = '0;
		ph_nx = '0;
		case (nxt)
			mp_pkg::slot_mag: xy_nx = lat_x;
			mp_pkg::slot_pha: begin
				xy_nx = lat_y;
				ph_nx = lat_p;
			end
			mp_pkg::slot_2: xy_nx = lat_set;
			mp_pkg::slot_3: ph_nx = lat_sp;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_sr <= '0;
			oslot <= mp_pkg::slot_7;
			out_xy <= '0;
			out_ph <= '0;
			lat_x <= '0;
			lat_y <= '0;
			lat_p <= '0;
			lat_sp <= '0;
			lat_set <= '0;
		end else begin
			sync_sr <= {sync_sr[mp_pkg::frame_len-2:0], sync};
			oslot <= nxt;
			out_xy <= xy_nx;
			out_ph <= ph_nx;
			// latched mid-frame, played out from the next out_sync
			if (take) begin
				lat_x <= drv.x;
				lat_y <= drv.y;
				lat_p <= drv_p;
				lat_sp <= set_p;
				lat_set <= set_prod[mp_pkg::set_shift +: mp_pkg::data_w];
			end
		end
	end

endmodule

/* design/mp_lock_detect.sv */
`timescale 1ns/10ps

module mp_lock_detect (
	input logic clk,
	input logic rst_n,
	mp_frame_if.dst err,
	input logic signed [mp_pkg::data_w-1:0] set_mag,
	input logic [3:0] clipped,
	output logic [7:0] cmp_event
);

	// one bit wider so abs of the most negative value fits
	logic signed [mp_pkg::data_w:0] abs_x;
	logic signed [mp_pkg::data_w:0] abs_y;
	logic signed [mp_pkg::data_w:0] thr_m;
	logic signed [mp_pkg::data_w:0] thr_m_half;
	logic [3:0] over;
	// high in the cycle the pi stage strobes
	logic stb_d;

	assign abs_x = err.x[mp_pkg::data_w-1] ? -err.x : err.x;
	assign abs_y = err.y[mp_pkg::data_w-1] ? -err.y : err.y;

	// magnitude threshold scales with the setpoint
	assign thr_m = set_mag >>> mp_pkg::thresh_shift;
	assign thr_m_half = thr_m >>> 1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			over <= '0;
			stb_d <= 1'b0;
			cmp_event <= '0;
		end else begin
			stb_d <= err.stb;
			if (err.stb) begin
				over[0] <= abs_x > thr_m;
				over[1] <= abs_x > thr_m_half;
				// phase thresholds are fixed, from one radian
				over[2] <= abs_y > (mp_pkg::ph_one_rad >> mp_pkg::thresh_shift);
				over[3] <= abs_y > (mp_pkg::ph_one_rad >> (mp_pkg::thresh_shift + 1));
			end
			// clip flags are valid one cycle after the error strobe
			// held until the next frame replaces them
			if (stb_d)
				cmp_event <= {clipped, over};
		end
	end

endmodule

/* design/mp_pi_clip.sv */
`timescale 1ns/10ps

module mp_pi_clip (
	input logic clk,
	input logic rst_n,
	mp_frame_if.dst err,
	input logic amp_ok,
	input logic [mp_pkg::gain_w-1:0] gain_kp,
	input logic [mp_pkg::gain_w-1:0] gain_ki,
	input logic signed [mp_pkg::data_w-1:0] lim_hi,
	input logic signed [mp_pkg::data_w-1:0] lim_lo,
	mp_frame_if.src drv,
	output logic [3:0] clipped
);

	// gains are unsigned, widen by one bit before the signed multiply
	logic signed [mp_pkg::gain_w:0] kp_s;
	logic signed [mp_pkg::gain_w:0] ki_s;
	// index 0 is x (magnitude), index 1 is y (phase)
	logic signed [mp_pkg::data_w-1:0] e [2];
	logic signed [mp_pkg::acc_w-1:0] integ [2];
	logic signed [mp_pkg::acc_w-1:0] integ_nx [2];
	logic signed [mp_pkg::prod_w-1:0] i_term [2];
	logic signed [mp_pkg::prod_w-1:0] p_term [2];
	logic signed [mp_pkg::sum_w-1:0] raw [2];
	logic signed [mp_pkg::data_w-1:0] sat [2];
	logic [1:0] hi;
	logic [1:0] lo;

	assign kp_s = $signed({1'b0, gain_kp});
	assign ki_s = $signed({1'b0, gain_ki});

	always_comb begin
		e[0] = err.x;
		e[1] = err.y;
		for (int a = 0; a < 2; a++) begin
			i_term[a] = (e[a] * ki_s) >>> mp_pkg::ki_shift;
			p_term[a] = (e[a] * kp_s) >>> mp_pkg::kp_shift;
			// candidate integrator, kept only if the drive stays in range
			integ_nx[a] = integ[a] + mp_pkg::acc_w'(i_term[a]);
			raw[a] = mp_pkg::sum_w'(integ_nx[a]) + mp_pkg::sum_w'(p_term[a]);
			hi[a] = raw[a] > mp_pkg::sum_w'(lim_hi);
			lo[a] = raw[a] < mp_pkg::sum_w'(lim_lo);
			if (hi[a])
				sat[a] = lim_hi;
			else if (lo[a])
				sat[a] = lim_lo;
			else
				sat[a] = raw[a][mp_pkg::data_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			integ[0] <= '0;
			integ[1] <= '0;
			drv.stb <= 1'b0;
			clipped <= '0;
		end else begin
			drv.stb <= err.stb;
			if (err.stb) begin
				// anti-windup, freeze the axis that clipped
				for (int a = 0; a < 2; a++) begin
					if (!(hi[a] || lo[a]))
						integ[a] <= integ_nx[a];
				end
				// no phase history at low amplitude
				if (!amp_ok)
					integ[1] <= '0;
				// x-high, y-high, x-low, y-low
				clipped <= {lo[1], lo[0], hi[1], hi[0]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (err.stb) begin
			drv.x <= sat[0];
			drv.y <= sat[1];
			drv.slot <= mp_pkg::mp_slot_e'(err.slot + 3'd1);
		end
	end

endmodule

/* design/mp_error_stage.sv */
`timescale 1ns/10ps

module mp_error_stage (
	input logic clk,
	input logic rst_n,
	mp_frame_if.dst meas,
	mp_frame_if.dst setp,
	input logic sel_en,
	input logic signed [mp_pkg::data_w-1:0] sel_thresh,
	input logic signed [mp_pkg::data_w-1:0] ph_offset,
	mp_frame_if.src err,
	output logic signed [mp_pkg::data_w-1:0] drv_p,
	output logic amp_ok
);

	logic take;
	// magnitude error before saturation
	logic signed [mp_pkg::data_w:0] mag_diff;
	logic signed [mp_pkg::data_w-1:0] mag_sat;
	logic above;
	logic below;

	// setp strobes together with meas from the same sequencer
	assign take = meas.stb;

	assign mag_diff = meas.x - setp.x;

	// clamp to the 18-bit range when the top two bits disagree
	always_comb begin
		if (mag_diff[mp_pkg::data_w] != mag_diff[mp_pkg::data_w-1])
			mag_sat = {mag_diff[mp_pkg::data_w], {(mp_pkg::data_w-1){~mag_diff[mp_pkg::data_w]}}};
		else
			mag_sat = mag_diff[mp_pkg::data_w-1:0];
	end

	// hysteresis band is sel_thresh/2 .. sel_thresh
	assign above = meas.x > sel_thresh;
	assign below = meas.x < (sel_thresh >>> 1);

	// phase is only worth anything at usable amplitude
	assign drv_p = (sel_en && amp_ok) ? meas.y + ph_offset : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			amp_ok <= 1'b0;
			err.stb <= 1'b0;
		end else begin
			err.stb <= take;
			if (take) begin
				if (above)
					amp_ok <= 1'b1;
				else if (below)
					amp_ok <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			err.x <= mag_sat;
			// phase wraps around the circle, no saturation
			err.y <= meas.y - setp.y;
			err.slot <= mp_pkg::mp_slot_e'(meas.slot + 3'd1);
		end
	end

endmodule

/* design/mp_setpoint_slew.sv */
`timescale 1ns/10ps

module mp_setpoint_slew (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input logic signed [mp_pkg::data_w-1:0] in_mp,
	input logic signed [mp_pkg::data_w-1:0] set_m,
	input logic signed [mp_pkg::data_w-1:0] set_p,
	input logic slew_en,
	mp_frame_if.src meas,
	mp_frame_if.src setp
);

	// slot_r holds the slot of the coming cycle, sync overrides it
	mp_pkg::mp_slot_e slot_r;
	mp_pkg::mp_slot_e cur;
	// nothing is strobed before the first sync
	logic run;
	logic signed [mp_pkg::data_w-1:0] mag_r;
	// one extra bit so the distance to set_m cannot overflow
	logic signed [mp_pkg::data_w:0] slew_diff;
	logic signed [mp_pkg::data_w-1:0] slew_nx;
	logic capture;

	assign cur = sync ? mp_pkg::slot_mag : slot_r;
	assign capture = run && (cur == mp_pkg::slot_pha);

	// setp.x doubles as the slewed setpoint state
	assign slew_diff = set_m - setp.x;

	always_comb begin
		if (!slew_en)
			slew_nx = set_m;
		else if (slew_diff > (mp_pkg::data_w+1)'(mp_pkg::slew_step))
			slew_nx = setp.x + mp_pkg::data_w'(mp_pkg::slew_step);
		else if (slew_diff < -(mp_pkg::data_w+1)'(mp_pkg::slew_step))
			slew_nx = setp.x - mp_pkg::data_w'(mp_pkg::slew_step);
		else
			slew_nx = set_m;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_r <= mp_pkg::slot_mag;
			run <= 1'b0;
			meas.stb <= 1'b0;
			setp.stb <= 1'b0;
			setp.x <= '0;
		end else begin
			slot_r <= mp_pkg::mp_slot_e'(cur + 3'd1);
			run <= run | sync;
			// both links strobe together, one cycle after the phase slot
			meas.stb <= capture;
			setp.stb <= capture;
			// setpoint steps once per frame
			if (capture)
				setp.x <= slew_nx;
		end
	end

	// magnitude arrives first, phase in the next cycle
	always_ff @(posedge clk) begin
		if (cur == mp_pkg::slot_mag)
			mag_r <= in_mp;
		if (capture) begin
			meas.x <= mag_r;
			meas.y <= in_mp;
			meas.slot <= mp_pkg::mp_slot_e'(cur + 3'd1);
			setp.y <= set_p;
			setp.slot <= mp_pkg::mp_slot_e'(cur + 3'd1);
		end
	end

endmodule

/* design/mp_frame_if.sv */
`timescale 1ns/10ps

// one data pair per frame between pipeline stages
// stb is high for a single cycle, no back-pressure
// x and y are only guaranteed until the next stb
interface mp_frame_if;

	// marks a complete x/y pair
	logic stb;
	// frame slot in which stb is high
	mp_pkg::mp_slot_e slot;
	logic signed [mp_pkg::data_w-1:0] x;
	logic signed [mp_pkg::data_w-1:0] y;

	modport src (
		output stb,
		output slot,
		output x,
		output y
	);

	modport dst (
		input stb,
		input slot,
		input x,
		input y
	);

endinterface

/* design/mp_pkg.sv */
package mp_pkg;

	// datapath word and integrator widths
	localparam int data_w = 18;
	localparam int acc_w = 24;
	localparam int gain_w = 12;
	// gain product, one spare bit for the unsigned gain made signed
	localparam int prod_w = data_w + gain_w + 1;
	// integrator plus proportional term, before clipping
	localparam int sum_w = prod_w + 1;

	// cycles per frame, sync to sync
	localparam int frame_len = 8;

	// slot within a frame, counted from sync
	typedef enum logic [2:0] {
		slot_mag,
		slot_pha,
		slot_2,
		slot_3,
		slot_4,
		slot_5,
		slot_6,
		slot_7
	} mp_slot_e;

	// coarse lock threshold is setpoint >> thresh_shift
	localparam int thresh_shift = 9;
	// one radian as an 18-bit fraction of a revolution
	localparam int ph_one_rad = 41722;
	// cordic gain correction for the x setpoint, 2^17*2/1.64676^2
	localparam int set_scale = 96667;
	localparam int set_shift = 17;
	// slewed setpoint moves at most this much per frame
	localparam int slew_step = 64;
	// pi term scaling
	localparam int ki_shift = 8;
	localparam int kp_shift = 4;

endpackage
